// ==== rtl/icache_pkg.sv ====
package icache_pkg;

    // 32 byte lines in 128 sets
    localparam int LINE_W   = 5;
    localparam int INDEX_W  = 7;
    localparam int TAG_W    = 32 - LINE_W - INDEX_W;
    localparam int WORD_W   = 3;
    localparam int NR_WORDS = 1 << WORD_W;

    // field view of a fetch address
    typedef struct packed {
        logic [TAG_W-1:0]         tag;
        logic [INDEX_W-1:0]       index;
        logic [WORD_W-1:0]        wsel;
        logic [LINE_W-WORD_W-1:0] boff;
    } fetch_fields_t;

    // flat for bus and compares, f for ram addressing
    typedef union packed {
        logic [31:0]   flat;
        fetch_fields_t f;
    } fetch_addr_u;

    typedef struct packed {
        logic        en;
        logic        no_cache;
        fetch_addr_u addr;
    } fetch_req_t;

    // read address channel payload
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } axi_r_t;

    // line address for refills, exact word address when uncached
    typedef struct packed {
        fetch_addr_u         addr;
        logic                no_cache;
        logic [WORD_W-1:0]   crit;
    } refill_cmd_t;

endpackage

// ==== rtl/icache_sdp_ram.sv ====
`timescale 1ns/100ps

module icache_sdp_ram #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_waddr,
    input  logic [DATA_W-1:0] i_wdata,
    input  logic              i_re,
    input  logic [ADDR_W-1:0] i_raddr,
    output logic [DATA_W-1:0] o_rdata
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // read returns old contents on an address collision
    always_ff @(posedge clk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

// ==== rtl/icache_lookup.sv ====
`timescale 1ns/100ps

module icache_lookup import icache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  fetch_req_t         i_fetch,
    input  logic               i_advance,
    input  logic [1:0]         i_tag_we,
    input  logic [1:0]         i_data_we,
    input  logic [INDEX_W-1:0] i_wr_index,
    input  logic [WORD_W-1:0]  i_wr_word,
    input  logic [TAG_W-1:0]   i_wr_tag,
    input  logic [31:0]        i_wr_data,
    input  logic [1:0]         i_valid_row,
    input  logic               i_lru_row,
    output fetch_req_t         o_req,
    output logic [1:0]         o_way_hit,
    output logic               o_victim,
    output logic [31:0]        o_hit_data
);

    logic [TAG_W-1:0] tag_q  [2];
    logic [31:0]      data_q [2];

    // request register sits beside the ram output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            o_req <= '0;
        end else if (i_advance) begin
            o_req <= i_fetch;
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_sdp_ram #(
            .DATA_W (TAG_W),
            .ADDR_W (INDEX_W)
        ) i_tag_ram (
            .clk     (clk),
            .i_we    (i_tag_we[w]),
            .i_waddr (i_wr_index),
            .i_wdata (i_wr_tag),
            .i_re    (i_advance),
            .i_raddr (i_fetch.addr.f.index),
            .o_rdata (tag_q[w])
        );

        icache_sdp_ram #(
            .DATA_W (32),
            .ADDR_W (INDEX_W + WORD_W)
        ) i_data_ram (
            .clk     (clk),
            .i_we    (i_data_we[w]),
            .i_waddr ({i_wr_index, i_wr_word}),
            .i_wdata (i_wr_data),
            .i_re    (i_advance),
            .i_raddr ({i_fetch.addr.f.index, i_fetch.addr.f.wsel}),
            .o_rdata (data_q[w])
        );

        // valid row is indexed by the registered request
        assign o_way_hit[w] = i_valid_row[w] && (tag_q[w] == o_req.addr.f.tag);
    end

    assign o_hit_data = o_way_hit[1] ? data_q[1] : data_q[0];

    // fill an empty way first, else evict the lru way
    always_comb begin
        if (!i_valid_row[0]) begin
            o_victim = 1'b0;
        end else if (!i_valid_row[1]) begin
            o_victim = 1'b1;
        end else begin
            o_victim = i_lru_row;
        end
    end

endmodule

// ==== rtl/icache_miss_ctrl.sv ====
`timescale 1ns/100ps

module icache_miss_ctrl import icache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_hold,
    input  fetch_req_t         i_req,
    input  logic [1:0]         i_way_hit,
    input  logic               i_victim,
    input  logic [31:0]        i_hit_data,
    input  logic               i_beat,
    input  logic [WORD_W-1:0]  i_beat_word,
    input  logic [31:0]        i_beat_data,
    input  logic [31:0]        i_crit_data,
    input  logic               i_done,
    output logic               o_advance,
    output logic               o_stall,
    output logic [31:0]        o_inst,
    output logic               o_inst_valid,
    output refill_cmd_t        o_cmd,
    output logic               o_cmd_start,
    output logic [1:0]         o_tag_we,
    output logic [1:0]         o_data_we,
    output logic [INDEX_W-1:0] o_wr_index,
    output logic [WORD_W-1:0]  o_wr_word,
    output logic [TAG_W-1:0]   o_wr_tag,
    output logic [31:0]        o_wr_data,
    output logic [1:0]         o_valid_row,
    output logic               o_lru_row
);

    localparam int NR_SETS = 1 << INDEX_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_UNCACHED
    } state_t;

    state_t             state;
    logic [1:0]         valid_arr [NR_SETS];
    logic [NR_SETS-1:0] lru_bits;
    fetch_req_t         miss_req;
    logic               victim_q;
    logic               hit;
    logic               miss;
    logic               uncached;
    logic               beat_in;
    logic               last_beat;
    logic [1:0]         way_mask;

    assign o_stall   = (state != ST_IDLE);
    assign o_advance = !i_hold || o_stall;

    assign hit      = i_req.en && !i_req.no_cache && (|i_way_hit);
    assign miss     = i_req.en && !i_req.no_cache && !(|i_way_hit);
    assign uncached = i_req.en && i_req.no_cache;

    assign o_valid_row = valid_arr[i_req.addr.f.index];
    assign o_lru_row   = lru_bits[i_req.addr.f.index];

    // refill beats go straight into the victim way
    assign way_mask  = victim_q ? 2'b10 : 2'b01;
    assign beat_in   = (state == ST_REFILL) && i_beat;
    assign last_beat = beat_in && (i_beat_word == WORD_W'(NR_WORDS - 1));

    assign o_data_we  = beat_in ? way_mask : 2'b00;
    assign o_tag_we   = last_beat ? way_mask : 2'b00;
    assign o_wr_index = miss_req.addr.f.index;
    assign o_wr_word  = i_beat_word;
    assign o_wr_tag   = miss_req.addr.f.tag;
    assign o_wr_data  = i_beat_data;

    // line aligned for refills, exact word otherwise
    always_comb begin
        o_cmd.addr     = miss_req.addr;
        o_cmd.no_cache = miss_req.no_cache;
        o_cmd.crit     = miss_req.addr.f.wsel;
        if (miss_req.no_cache) begin
            o_cmd.crit = '0;
        end else begin
            o_cmd.addr.f.wsel = '0;
            o_cmd.addr.f.boff = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            o_inst_valid <= 1'b0;
            o_cmd_start  <= 1'b0;
            valid_arr    <= '{default: 2'b00};
            lru_bits     <= '0;
        end else begin
            o_cmd_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (o_advance) begin
                        o_inst_valid <= hit;
                        if (hit) begin
                            // other way becomes the lru one
                            lru_bits[i_req.addr.f.index] <= !i_way_hit[1];
                        end
                        if (miss) begin
                            state       <= ST_REFILL;
                            o_cmd_start <= 1'b1;
                        end else if (uncached) begin
                            state       <= ST_UNCACHED;
                            o_cmd_start <= 1'b1;
                        end
                    end
                end
                ST_REFILL: begin
                    o_inst_valid <= i_done;
                    if (last_beat) begin
                        valid_arr[miss_req.addr.f.index][victim_q] <= 1'b1;
                    end
                    if (i_done) begin
                        lru_bits[miss_req.addr.f.index] <= !victim_q;
                        state <= ST_IDLE;
                    end
                end
                ST_UNCACHED: begin
                    o_inst_valid <= i_done;
                    if (i_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // payload side
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && o_advance) begin
            if (hit) begin
                o_inst <= i_hit_data;
            end
            if (miss || uncached) begin
                miss_req <= i_req;
                victim_q <= i_victim;
            end
        end else if (i_done) begin
            o_inst <= i_crit_data;
        end
    end

endmodule

// ==== rtl/icache_axi_read.sv ====
`timescale 1ns/100ps

module icache_axi_read import icache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  refill_cmd_t       i_cmd,
    input  logic              i_cmd_start,
    output axi_ar_t           o_ar,
    output logic              o_arvalid,
    input  logic              i_arready,
    input  axi_r_t            i_r,
    input  logic              i_rvalid,
    output logic              o_rready,
    output logic              o_beat,
    output logic [WORD_W-1:0] o_beat_word,
    output logic [31:0]       o_beat_data,
    output logic [31:0]       o_crit_data,
    output logic              o_done
);

    logic [WORD_W-1:0] beat_cnt;
    logic [WORD_W-1:0] crit_sel;

    assign o_beat      = i_rvalid && o_rready;
    assign o_beat_word = beat_cnt;
    assign o_beat_data = i_r.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_arvalid <= 1'b0;
            o_rready  <= 1'b0;
            o_done    <= 1'b0;
            beat_cnt  <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_cmd_start) begin
                o_arvalid <= 1'b1;
                beat_cnt  <= '0;
            end else if (o_arvalid && i_arready) begin
                o_arvalid <= 1'b0;
                o_rready  <= 1'b1;
            end
            // only accepted beats advance the count
            if (o_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (i_r.last) begin
                    o_rready <= 1'b0;
                    o_done   <= 1'b1;
                end
            end
        end
    end

    // address payload stays put while arvalid is up
    always_ff @(posedge clk) begin
        if (i_cmd_start) begin
            o_ar.addr <= i_cmd.addr.flat;
            o_ar.len  <= i_cmd.no_cache ? 8'd0 : 8'(NR_WORDS - 1);
            o_ar.size <= 3'd2;
            crit_sel  <= i_cmd.crit;
        end
    end

    // grab the requested word as it streams past
    always_ff @(posedge clk) begin
        if (o_beat && beat_cnt == crit_sel) begin
            o_crit_data <= i_r.data;
        end
    end

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/100ps

module icache_top import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  fetch_req_t  i_fetch,
    input  logic        i_hold,
    output logic [31:0] o_inst,
    output logic        o_inst_valid,
    output logic        o_stall,
    output axi_ar_t     o_ar,
    output logic        o_arvalid,
    input  logic        i_arready,
    input  axi_r_t      i_r,
    input  logic        i_rvalid,
    output logic        o_rready
);

    fetch_req_t         req;
    logic               advance;
    logic [1:0]         way_hit;
    logic               victim;
    logic [31:0]        hit_data;
    logic [1:0]         tag_we;
    logic [1:0]         data_we;
    logic [INDEX_W-1:0] wr_index;
    logic [WORD_W-1:0]  wr_word;
    logic [TAG_W-1:0]   wr_tag;
    logic [31:0]        wr_data;
    logic [1:0]         valid_row;
    logic               lru_row;
    refill_cmd_t        cmd;
    logic               cmd_start;
    logic               beat;
    logic [WORD_W-1:0]  beat_word;
    logic [31:0]        beat_data;
    logic [31:0]        crit_data;
    logic               done;

    icache_lookup i_lookup (
        .clk         (clk),
        .rst         (rst),
        .i_fetch     (i_fetch),
        .i_advance   (advance),
        .i_tag_we    (tag_we),
        .i_data_we   (data_we),
        .i_wr_index  (wr_index),
        .i_wr_word   (wr_word),
        .i_wr_tag    (wr_tag),
        .i_wr_data   (wr_data),
        .i_valid_row (valid_row),
        .i_lru_row   (lru_row),
        .o_req       (req),
        .o_way_hit   (way_hit),
        .o_victim    (victim),
        .o_hit_data  (hit_data)
    );

    icache_miss_ctrl i_miss_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_hold       (i_hold),
        .i_req        (req),
        .i_way_hit    (way_hit),
        .i_victim     (victim),
        .i_hit_data   (hit_data),
        .i_beat       (beat),
        .i_beat_word  (beat_word),
        .i_beat_data  (beat_data),
        .i_crit_data  (crit_data),
        .i_done       (done),
        .o_advance    (advance),
        .o_stall      (o_stall),
        .o_inst       (o_inst),
        .o_inst_valid (o_inst_valid),
        .o_cmd        (cmd),
        .o_cmd_start  (cmd_start),
        .o_tag_we     (tag_we),
        .o_data_we    (data_we),
        .o_wr_index   (wr_index),
        .o_wr_word    (wr_word),
        .o_wr_tag     (wr_tag),
        .o_wr_data    (wr_data),
        .o_valid_row  (valid_row),
        .o_lru_row    (lru_row)
    );

    icache_axi_read i_axi_read (
        .clk         (clk),
        .rst         (rst),
        .i_cmd       (cmd),
        .i_cmd_start (cmd_start),
        .o_ar        (o_ar),
        .o_arvalid   (o_arvalid),
        .i_arready   (i_arready),
        .i_r         (i_r),
        .i_rvalid    (i_rvalid),
        .o_rready    (o_rready),
        .o_beat      (beat),
        .o_beat_word (beat_word),
        .o_beat_data (beat_data),
        .o_crit_data (crit_data),
        .o_done      (done)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// ==== testbench/axi_mem_model.sv ====
`timescale 1ns/100ps

module axi_mem_model import icache_pkg::*; (
    input  logic    clk,
    input  axi_ar_t i_ar,
    input  logic    i_arvalid,
    output logic    o_arready,
    output axi_r_t  o_r,
    output logic    o_rvalid,
    input  logic    i_rready
);

    int          burst_cnt;
    logic [7:0]  last_len;
    logic [2:0]  last_size;
    logic [31:0] last_addr;

    // each word holds its own address xor a fixed pattern
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    initial begin
        int unsigned gap;
        o_arready <= 1'b0;
        o_rvalid  <= 1'b0;
        o_r       <= '0;
        burst_cnt = 0;
        last_len  = '0;
        last_size = '0;
        last_addr = '0;
        void'($urandom(32'h425f));
        forever begin
            @(posedge clk);
            if (i_arvalid && o_arready) begin
                o_arready <= 1'b0;
                burst_cnt++;
                last_len  = i_ar.len;
                last_size = i_ar.size;
                last_addr = i_ar.addr;
                for (int i = 0; i <= int'(last_len); i++) begin
                    // idle gap of up to two cycles before each beat
                    gap = $urandom_range(2);
                    if (gap != 0) begin
                        o_rvalid <= 1'b0;
                        repeat (gap) @(posedge clk);
                    end
                    o_r.data <= word_at(last_addr + 32'(4 * i));
                    o_r.last <= (i == int'(last_len));
                    o_rvalid <= 1'b1;
                    do @(posedge clk); while (!i_rready);
                end
                o_rvalid <= 1'b0;
            end else if (i_arvalid) begin
                repeat ($urandom_range(2)) @(posedge clk);
                o_arready <= 1'b1;
            end
        end
    end

endmodule

// ==== testbench/tb_icache.sv ====
`timescale 1ns/100ps

module tb_icache import icache_pkg::*; ();

    localparam int          NR_ROWS     = 13;
    localparam int          CYCLE_BOUND = 200;
    localparam logic [31:0] SCRAMBLE    = 32'h5a5a0000;

    typedef struct {
        string       name;
        logic [31:0] addr;
        logic        no_cache;
        logic [3:0]  hold;
        int          bursts;
    } row_t;

    // name, address, uncached, hold bits (lsb first), new bursts
    // tags 1, 2 and 3 share set 3, so the third one must evict
    row_t rows [NR_ROWS] = '{
        '{"cold_miss",      32'h0001_0060, 1'b0, 4'b0000, 1},
        '{"hit_same_line",  32'h0001_006c, 1'b0, 4'b0000, 0},
        '{"hit_last_word",  32'h0001_007c, 1'b0, 4'b0000, 0},
        '{"fill_b_crit",    32'h0002_0064, 1'b0, 4'b0000, 1},
        '{"hit_a",          32'h0001_0068, 1'b0, 4'b0000, 0},
        '{"miss_c_crit",    32'h0003_0074, 1'b0, 4'b0000, 1},
        '{"hit_a_after_c",  32'h0001_0070, 1'b0, 4'b0000, 0},
        '{"miss_b_again",   32'h0002_0078, 1'b0, 4'b0000, 1},
        '{"uncached",       32'h0004_0128, 1'b1, 4'b0000, 1},
        '{"uncached_again", 32'h0004_0128, 1'b1, 4'b0000, 1},
        '{"hold_hit",       32'h0002_0060, 1'b0, 4'b1011, 0},
        '{"hold_miss",      32'h0005_0004, 1'b0, 4'b0110, 1},
        '{"hold_hit_new",   32'h0005_001c, 1'b0, 4'b0101, 0}
    };

    logic        clk;
    logic        rst;
    fetch_req_t  fetch;
    logic        hold;
    logic [31:0] inst;
    logic        inst_valid;
    logic        stall;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;
    int          err_cnt = 0;
    int          chk_cnt = 0;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (8)
    ) i_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    axi_mem_model i_mem (
        .clk       (clk),
        .i_ar      (ar),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .o_r       (r),
        .o_rvalid  (rvalid),
        .i_rready  (rready)
    );

    icache_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_fetch      (fetch),
        .i_hold       (hold),
        .o_inst       (inst),
        .o_inst_valid (inst_valid),
        .o_stall      (stall),
        .o_ar         (ar),
        .o_arvalid    (arvalid),
        .i_arready    (arready),
        .i_r          (r),
        .i_rvalid     (rvalid),
        .o_rready     (rready)
    );

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic apply_row(input int idx);
        row_t       row;
        logic [3:0] hold_bits;
        logic       got;
        logic       saw_stall;
        int         bursts_before;
        row           = rows[idx];
        hold_bits     = row.hold;
        got           = 1'b0;
        saw_stall     = 1'b0;
        bursts_before = i_mem.burst_cnt;
        @(posedge clk);
        hold <= 1'b0;
        @(posedge clk);
        fetch <= {1'b1, row.no_cache, row.addr};
        // one cycle of request, then hold bits while waiting
        while (!got) begin
            @(posedge clk);
            fetch.en <= 1'b0;
            hold     <= hold_bits[0];
            hold_bits = hold_bits >> 1;
            @(negedge clk);
            saw_stall = saw_stall | stall;
            got       = inst_valid;
        end
        check({row.name, " word"}, row.addr ^ SCRAMBLE, inst);
        check({row.name, " stall at result"}, 32'd0, 32'(stall));
        check({row.name, " bursts"}, 32'(row.bursts), 32'(i_mem.burst_cnt - bursts_before));
        if (row.bursts == 0) begin
            check({row.name, " stall seen"}, 32'd0, 32'(saw_stall));
        end else begin
            check({row.name, " len"}, row.no_cache ? 32'd0 : 32'd7, 32'(i_mem.last_len));
            check({row.name, " ar size"}, 32'd2, 32'(i_mem.last_size));
            check({row.name, " ar addr"},
                  row.no_cache ? row.addr : {row.addr[31:5], 5'b0}, i_mem.last_addr);
        end
    endtask

    // one fetch per cycle into a line that is already cached
    task automatic stream_hits(input logic [31:0] base, input int n);
        int bursts_before;
        bursts_before = i_mem.burst_cnt;
        @(posedge clk);
        hold <= 1'b0;
        for (int k = 0; k < n + 2; k++) begin
            @(posedge clk);
            if (k < n) begin
                fetch <= {1'b1, 1'b0, base + 32'(4 * k)};
            end else begin
                fetch.en <= 1'b0;
            end
            @(negedge clk);
            if (k >= 2) begin
                check("stream valid", 32'd1, 32'(inst_valid));
                check("stream stall", 32'd0, 32'(stall));
                check("stream word", (base + 32'(4 * (k - 2))) ^ SCRAMBLE, inst);
            end
        end
        check("stream bursts", 32'd0, 32'(i_mem.burst_cnt - bursts_before));
    endtask

    initial begin
        fetch <= '0;
        hold  <= 1'b0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        // stall, result valid and both bus handshakes come out of reset low
        @(negedge clk);
        check("reset outputs", 32'd0, 32'({stall, inst_valid, arvalid, rready}));
        for (int i = 0; i < NR_ROWS; i++) begin
            apply_row(i);
        end
        stream_hits(32'h0002_0060, 4);
        $display("summary: %0d errors in %0d checks", err_cnt, chk_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // extra row's worth of cycles covers reset and the hit stream
    initial begin
        repeat ((NR_ROWS + 1) * CYCLE_BOUND) @(posedge clk);
        $display("timeout: no result after %0d cycles, %0d errors so far",
                 (NR_ROWS + 1) * CYCLE_BOUND, err_cnt);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== all.f ====
rtl/icache_pkg.sv
rtl/icache_sdp_ram.sv
rtl/icache_lookup.sv
rtl/icache_miss_ctrl.sv
rtl/icache_axi_read.sv
rtl/icache_top.sv
testbench/tb_clock_gen.sv
testbench/axi_mem_model.sv
testbench/tb_icache.sv

// ==== Makefile ====
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
